//--- verilog/lms_types_pkg.sv
`default_nettype none

package lms_types_pkg;

  // ----------------------------------------------------------------------
  // Sample and tap formats, all signed fixed point
  // ----------------------------------------------------------------------
  localparam int SAMPLE_W = 16;
  localparam int TAP_W    = 16;
  localparam int PROD_W   = SAMPLE_W + TAP_W;

  // ----------------------------------------------------------------------
  // Filter geometry
  // ----------------------------------------------------------------------
  localparam int NUM_TAPS   = 4;
  localparam int NUM_PHASES = 4;
  localparam int PHASE_W    = $clog2(NUM_PHASES);

  // One memory row per phase, tap i at bits TAP_W*i upward
  localparam int ROW_W = NUM_TAPS * TAP_W;
  // Data window, newest sample in element 0
  localparam int WIN_W = NUM_TAPS * SAMPLE_W;

  // Exact width of the sum of NUM_TAPS products
  localparam int ACC_W = PROD_W + $clog2(NUM_TAPS);

  // Step size of the adaptation as a power of two
  localparam int STEP_SHIFT = 8;

endpackage

`default_nettype wire

//--- verilog/lms_ctrl_pkg.sv
`default_nettype none

package lms_ctrl_pkg;

  // Requesters on the shared tap memory
  typedef enum logic [1:0] {
    OWNER_NONE,
    OWNER_LOAD,
    OWNER_UPDATE,
    OWNER_FILTER
  } mem_owner_e;

  // Filter output sequence
  typedef enum logic [1:0] {
    FIR_IDLE,
    FIR_REQUEST,
    FIR_WAIT,
    FIR_SUM
  } fir_state_e;

  // Read-modify-write of one row
  typedef enum logic [1:0] {
    UPD_IDLE,
    UPD_READ,
    UPD_WAIT,
    UPD_WRITE
  } upd_state_e;

endpackage

`default_nettype wire

//--- verilog/tap_memory.sv
`default_nettype none

module tap_memory import lms_types_pkg::*; (
  input  wire                clk,
  input  wire                we,
  input  wire  [PHASE_W-1:0] addr,
  input  wire  [ROW_W-1:0]   wdata,
  output logic [ROW_W-1:0]   rdata
);

  // One row of taps per phase
  logic [ROW_W-1:0] rows [NUM_PHASES];

  // Single port, read data registered every cycle.
  // A write cycle returns the old row.
  always_ff @(posedge clk) begin
    if (we) begin
      rows[addr] <= wdata;
    end
    rdata <= rows[addr];
  end

endmodule

`default_nettype wire

//--- verilog/tap_mem_arbiter.sv
`default_nettype none

module tap_mem_arbiter import lms_types_pkg::*, lms_ctrl_pkg::*; (
  input  wire                clk,
  input  wire                reset,
  input  wire                load_req,
  input  wire  [PHASE_W-1:0] load_addr,
  input  wire  [ROW_W-1:0]   load_wdata,
  input  wire                upd_req,
  input  wire                upd_we,
  input  wire  [PHASE_W-1:0] upd_addr,
  input  wire  [ROW_W-1:0]   upd_wdata,
  input  wire                fir_req,
  input  wire  [PHASE_W-1:0] fir_addr,
  output logic               load_gnt,
  output logic               upd_gnt,
  output logic               fir_gnt,
  output logic               mem_we,
  output logic [PHASE_W-1:0] mem_addr,
  output logic [ROW_W-1:0]   mem_wdata
);

  mem_owner_e owner;

  // Fixed priority of host load over update over filter
  always_comb begin
    if (load_req) begin
      owner = OWNER_LOAD;
    end else if (upd_req) begin
      owner = OWNER_UPDATE;
    end else if (fir_req) begin
      owner = OWNER_FILTER;
    end else begin
      owner = OWNER_NONE;
    end
  end

  assign load_gnt = (owner == OWNER_LOAD);
  assign upd_gnt  = (owner == OWNER_UPDATE);
  assign fir_gnt  = (owner == OWNER_FILTER);

  // ----------------------------------------------------------------------
  // Memory port mux
  // ----------------------------------------------------------------------
  always_comb begin
    mem_we    = 1'b0;
    mem_addr  = fir_addr;
    mem_wdata = load_wdata;
    case (owner)
      OWNER_LOAD: begin
        mem_we   = 1'b1;
        mem_addr = load_addr;
      end
      OWNER_UPDATE: begin
        mem_we    = upd_we;
        mem_addr  = upd_addr;
        mem_wdata = upd_wdata;
      end
      default: begin
        mem_we = 1'b0;
      end
    endcase
  end

  // Losers keep asking until served
  assert property (@(posedge clk) disable iff (reset)
    upd_req && !upd_gnt |=> upd_req);
  assert property (@(posedge clk) disable iff (reset)
    fir_req && !fir_gnt |=> fir_req);

endmodule

`default_nettype wire

//--- verilog/stage_ctrl.sv
`default_nettype none

module stage_ctrl import lms_types_pkg::*; (
  input  wire                clk,
  input  wire                reset,
  input  wire                sample_strobe,
  input  wire                load_strobe,
  input  wire  [PHASE_W-1:0] load_phase,
  input  wire  [ROW_W-1:0]   load_row,
  input  wire                y_valid,
  input  wire                load_gnt,
  output logic [PHASE_W-1:0] phase,
  output logic [PHASE_W-1:0] last_phase,
  output logic               load_req,
  output logic [PHASE_W-1:0] load_addr,
  output logic [ROW_W-1:0]   load_wdata
);

  // ----------------------------------------------------------------------
  // Phase rotation
  // ----------------------------------------------------------------------
  // sample_strobe here is the accepted sample from the filter
  always_ff @(posedge clk) begin
    if (reset) begin
      phase      <= '0;
      last_phase <= '0;
    end else begin
      if (sample_strobe) begin
        phase <= (phase == PHASE_W'(NUM_PHASES - 1)) ? '0 : phase + 1'b1;
      end
      // Phase already moved on, the output used the previous one
      if (y_valid) begin
        last_phase <= (phase == '0) ? PHASE_W'(NUM_PHASES - 1) : phase - 1'b1;
      end
    end
  end

  // Host load, held until granted
  always_ff @(posedge clk) begin
    if (reset) begin
      load_req <= 1'b0;
    end else if (load_gnt) begin
      load_req <= 1'b0;
    end else if (load_strobe) begin
      load_req <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_strobe && !load_req) begin
      load_addr  <= load_phase;
      load_wdata <= load_row;
    end
  end

  // Load has top priority, so it never waits
  assert property (@(posedge clk) disable iff (reset) load_req |-> load_gnt);

endmodule

`default_nettype wire

//--- verilog/fir_output.sv
`default_nettype none

module fir_output import lms_types_pkg::*, lms_ctrl_pkg::*; (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       sample_strobe,
  input  wire  signed [SAMPLE_W-1:0] sample,
  input  wire         [PHASE_W-1:0] phase,
  input  wire                       fir_gnt,
  input  wire         [ROW_W-1:0]   mem_rdata,
  output logic                      fir_req,
  output logic        [PHASE_W-1:0] fir_addr,
  output logic                      accept,
  output logic        [WIN_W-1:0]   window,
  output logic signed [ACC_W-1:0]   y,
  output logic                      y_valid,
  output logic                      overrun
);

  fir_state_e state;
  logic signed [ACC_W-1:0] dot;

  assign accept  = sample_strobe && (state == FIR_IDLE);
  assign fir_req = (state == FIR_REQUEST);
  assign y_valid = (state == FIR_SUM);

  // Sum of tap i times window i, full precision
  always_comb begin
    dot = '0;
    for (int i = 0; i < NUM_TAPS; i++) begin
      dot = dot + $signed(mem_rdata[i*TAP_W +: TAP_W])
                * $signed(window[i*SAMPLE_W +: SAMPLE_W]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= FIR_IDLE;
      window  <= '0;
      overrun <= 1'b0;
    end else begin
      // Busy stage drops the sample, flag sticks until reset
      if (sample_strobe && state != FIR_IDLE) begin
        overrun <= 1'b1;
      end
      case (state)
        FIR_IDLE: begin
          if (accept) begin
            window <= {window[WIN_W-SAMPLE_W-1:0], sample};
            state  <= FIR_REQUEST;
          end
        end
        FIR_REQUEST: begin
          if (fir_gnt) begin
            state <= FIR_WAIT;
          end
        end
        // Row arrives in this cycle
        FIR_WAIT: state <= FIR_SUM;
        default:  state <= FIR_IDLE;
      endcase
    end
  end

  // Row address and result
  always_ff @(posedge clk) begin
    if (accept) begin
      fir_addr <= phase;
    end
    if (state == FIR_WAIT) begin
      y <= dot;
    end
  end

endmodule

`default_nettype wire

//--- verilog/tap_update.sv
`default_nettype none

module tap_update import lms_types_pkg::*, lms_ctrl_pkg::*; (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        err_strobe,
  input  wire  signed [SAMPLE_W-1:0] err,
  input  wire         [PHASE_W-1:0]  last_phase,
  input  wire         [WIN_W-1:0]    window,
  input  wire                        upd_gnt,
  input  wire         [ROW_W-1:0]    mem_rdata,
  output logic                       upd_req,
  output logic                       upd_we,
  output logic        [PHASE_W-1:0]  upd_addr,
  output logic        [ROW_W-1:0]    upd_wdata,
  output logic                       update_busy
);

  upd_state_e state;
  logic                       start;
  logic signed [SAMPLE_W-1:0] err_q;
  logic        [WIN_W-1:0]    win_q;
  logic        [ROW_W-1:0]    new_row;

  assign start       = err_strobe && (state == UPD_IDLE);
  assign upd_req     = (state == UPD_READ) || (state == UPD_WRITE);
  assign upd_we      = (state == UPD_WRITE);
  assign update_busy = (state != UPD_IDLE);

  // Each tap gains (err * x) >>> STEP_SHIFT and wraps to TAP_W
  always_comb begin
    logic signed [PROD_W-1:0] prod;
    for (int i = 0; i < NUM_TAPS; i++) begin
      prod = err_q * $signed(win_q[i*SAMPLE_W +: SAMPLE_W]);
      new_row[i*TAP_W +: TAP_W] = mem_rdata[i*TAP_W +: TAP_W]
                                + TAP_W'(prod >>> STEP_SHIFT);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= UPD_IDLE;
    end else begin
      case (state)
        UPD_IDLE:  state <= start ? UPD_READ : UPD_IDLE;
        UPD_READ:  state <= upd_gnt ? UPD_WAIT : UPD_READ;
        UPD_WAIT:  state <= UPD_WRITE;
        default:   state <= upd_gnt ? UPD_IDLE : UPD_WRITE;
      endcase
    end
  end

  // Snapshot of the error, its row and the window
  always_ff @(posedge clk) begin
    if (start) begin
      err_q    <= err;
      upd_addr <= last_phase;
      win_q    <= window;
    end
    if (state == UPD_WAIT) begin
      upd_wdata <= new_row;
    end
  end

endmodule

`default_nettype wire

//--- verilog/lms_stage_top.sv
`default_nettype none

module lms_stage_top import lms_types_pkg::*; (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        sample_strobe,
  input  wire  signed [SAMPLE_W-1:0] sample,
  input  wire                        err_strobe,
  input  wire  signed [SAMPLE_W-1:0] err,
  input  wire                        load_strobe,
  input  wire         [PHASE_W-1:0]  load_phase,
  input  wire         [ROW_W-1:0]    load_row,
  output wire  signed [ACC_W-1:0]    y,
  output wire                        y_valid,
  output wire                        overrun,
  output wire                        update_busy
);

  logic [PHASE_W-1:0] phase;
  logic [PHASE_W-1:0] last_phase;
  logic               accept;
  logic [WIN_W-1:0]   window;

  // ----------------------------------------------------------------------
  // Tap memory port, one set per requester
  // ----------------------------------------------------------------------
  logic               load_req, load_gnt;
  logic [PHASE_W-1:0] load_addr;
  logic [ROW_W-1:0]   load_wdata;
  logic               upd_req, upd_we, upd_gnt;
  logic [PHASE_W-1:0] upd_addr;
  logic [ROW_W-1:0]   upd_wdata;
  logic               fir_req, fir_gnt;
  logic [PHASE_W-1:0] fir_addr;
  logic               mem_we;
  logic [PHASE_W-1:0] mem_addr;
  logic [ROW_W-1:0]   mem_wdata;
  logic [ROW_W-1:0]   mem_rdata;

  // Phase only advances on samples the filter took
  stage_ctrl u_ctrl (
    .clk, .reset, .sample_strobe(accept), .load_strobe, .load_phase, .load_row,
    .y_valid, .load_gnt, .phase, .last_phase, .load_req, .load_addr, .load_wdata
  );

  fir_output u_fir (
    .clk, .reset, .sample_strobe, .sample, .phase, .fir_gnt, .mem_rdata,
    .fir_req, .fir_addr, .accept, .window, .y, .y_valid, .overrun
  );

  tap_update u_upd (
    .clk, .reset, .err_strobe, .err, .last_phase, .window, .upd_gnt, .mem_rdata,
    .upd_req, .upd_we, .upd_addr, .upd_wdata, .update_busy
  );

  tap_mem_arbiter u_arb (
    .clk, .reset, .load_req, .load_addr, .load_wdata,
    .upd_req, .upd_we, .upd_addr, .upd_wdata, .fir_req, .fir_addr,
    .load_gnt, .upd_gnt, .fir_gnt, .mem_we, .mem_addr, .mem_wdata
  );

  tap_memory u_mem (
    .clk, .we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
  );

endmodule

`default_nettype wire

//--- tests/lms_stage_tb.sv
`default_nettype none

module lms_stage_tb import lms_types_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 100;

  logic                       clk;
  logic                       reset;
  logic                       sample_strobe;
  logic signed [SAMPLE_W-1:0] sample;
  logic                       err_strobe;
  logic signed [SAMPLE_W-1:0] err;
  logic                       load_strobe;
  logic        [PHASE_W-1:0]  load_phase;
  logic        [ROW_W-1:0]    load_row;
  wire  signed [ACC_W-1:0]    y;
  wire                        y_valid;
  wire                        overrun;
  wire                        update_busy;

  // Reference model state
  logic signed [TAP_W-1:0]    m_taps [NUM_PHASES][NUM_TAPS];
  logic signed [SAMPLE_W-1:0] m_win [NUM_TAPS];
  int                         m_phase;
  int                         m_last;
  logic        [31:0]         rng_state;
  int                         checks;
  int                         errors;

  lms_stage_top dut (
    .clk, .reset, .sample_strobe, .sample, .err_strobe, .err,
    .load_strobe, .load_phase, .load_row, .y, .y_valid, .overrun, .update_busy
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // ----------------------------------------------------------------------
  // Model of the window, the dot product and the tap update
  // ----------------------------------------------------------------------
  function automatic void model_shift(input logic signed [SAMPLE_W-1:0] s);
    for (int i = NUM_TAPS - 1; i > 0; i--) begin
      m_win[i] = m_win[i-1];
    end
    m_win[0] = s;
  endfunction

  function automatic logic signed [ACC_W-1:0] model_dot(input int ph);
    logic signed [ACC_W-1:0]  acc;
    logic signed [PROD_W-1:0] p;
    acc = '0;
    for (int i = 0; i < NUM_TAPS; i++) begin
      p   = m_taps[ph][i] * m_win[i];
      acc = acc + p;
    end
    return acc;
  endfunction

  // Each tap moves by (err * x) >>> STEP_SHIFT and wraps
  function automatic void model_update(input int ph, input logic signed [SAMPLE_W-1:0] e,
                                       input logic signed [SAMPLE_W-1:0] w [NUM_TAPS]);
    logic signed [PROD_W-1:0] p;
    for (int i = 0; i < NUM_TAPS; i++) begin
      p = e * w[i];
      m_taps[ph][i] = m_taps[ph][i] + TAP_W'(p >>> STEP_SHIFT);
    end
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic wait_output();
    for (int n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if (y_valid) break;
    end
    if (!y_valid) begin
      errors++;
      $display("Timeout: y_valid did not pulse within %0d cycles", TIMEOUT);
    end
  endtask

  task automatic wait_update_done();
    for (int n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if (!update_busy) break;
    end
    if (update_busy) begin
      errors++;
      $display("Timeout: update_busy stayed high for %0d cycles", TIMEOUT);
    end
  endtask

  task automatic load_tap_row(input int ph, input logic [ROW_W-1:0] row);
    @(posedge clk);
    load_strobe <= 1'b1;
    load_phase  <= PHASE_W'(ph);
    load_row    <= row;
    @(posedge clk);
    load_strobe <= 1'b0;
    // Request rises here and the write lands on the next edge
    @(posedge clk);
    for (int i = 0; i < NUM_TAPS; i++) begin
      m_taps[ph][i] = row[i*TAP_W +: TAP_W];
    end
  endtask

  // Send one sample and check the output it produces
  task automatic issue_sample(input logic signed [SAMPLE_W-1:0] s,
                              input logic signed [ACC_W-1:0] exp);
    m_last  = m_phase;
    m_phase = (m_phase + 1) % NUM_PHASES;
    @(posedge clk);
    sample_strobe <= 1'b1;
    sample        <= s;
    @(posedge clk);
    sample_strobe <= 1'b0;
    wait_output();
    check_value("y", y, exp);
  endtask

  task automatic run_sample(input logic signed [SAMPLE_W-1:0] s);
    model_shift(s);
    issue_sample(s, model_dot(m_phase));
  endtask

  task automatic apply_error(input logic signed [SAMPLE_W-1:0] e);
    @(posedge clk);
    err_strobe <= 1'b1;
    err        <= e;
    @(posedge clk);
    err_strobe <= 1'b0;
    model_update(m_last, e, m_win);
    wait_update_done();
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic test_reset_state();
    @(negedge clk);
    check_value("y_valid", y_valid, 0);
    check_value("overrun", overrun, 0);
    check_value("update_busy", update_busy, 0);
  endtask

  task automatic test_impulse();
    logic signed [ACC_W-1:0] exp;
    for (int ph = 0; ph < NUM_PHASES; ph++) begin
      load_tap_row(ph, {xorshift32(), xorshift32()});
    end
    // The 1 walks through window slot k while the phase rotates
    for (int k = 0; k < NUM_TAPS; k++) begin
      model_shift((k == 0) ? 16'sd1 : 16'sd0);
      exp = m_taps[m_phase][k];
      issue_sample((k == 0) ? 16'sd1 : 16'sd0, exp);
    end
  endtask

  task automatic test_random_filtering();
    for (int n = 0; n < 12; n++) begin
      run_sample(xorshift32());
    end
  endtask

  task automatic test_adaptation();
    for (int r = 0; r < 2; r++) begin
      run_sample(xorshift32());
      apply_error(xorshift32());
      for (int n = 0; n < NUM_PHASES; n++) begin
        run_sample(xorshift32());
      end
    end
  endtask

  task automatic test_contention();
    logic signed [SAMPLE_W-1:0] old_win [NUM_TAPS];
    logic signed [SAMPLE_W-1:0] s;
    logic signed [SAMPLE_W-1:0] e;
    logic signed [ACC_W-1:0]    exp;
    s = xorshift32();
    e = xorshift32();
    old_win = m_win;
    model_shift(s);
    // Filter read is granted before the update writes back
    exp = model_dot(m_phase);
    model_update(m_last, e, old_win);
    m_last  = m_phase;
    m_phase = (m_phase + 1) % NUM_PHASES;
    @(posedge clk);
    sample_strobe <= 1'b1;
    sample        <= s;
    err_strobe    <= 1'b1;
    err           <= e;
    @(posedge clk);
    sample_strobe <= 1'b0;
    err_strobe    <= 1'b0;
    // Update starts alongside the row fetch
    @(negedge clk);
    check_value("update_busy", update_busy, 1);
    wait_output();
    check_value("y", y, exp);
    wait_update_done();
    for (int n = 0; n < NUM_PHASES; n++) begin
      run_sample(xorshift32());
    end
  endtask

  task automatic test_overrun();
    logic signed [SAMPLE_W-1:0] s;
    s = xorshift32();
    check_value("overrun", overrun, 0);
    model_shift(s);
    m_last  = m_phase;
    @(posedge clk);
    sample_strobe <= 1'b1;
    sample        <= s;
    @(posedge clk);
    // Second sample lands while the row fetch is pending
    sample <= xorshift32();
    @(posedge clk);
    sample_strobe <= 1'b0;
    wait_output();
    check_value("y", y, model_dot(m_phase));
    m_phase = (m_phase + 1) % NUM_PHASES;
    check_value("overrun", overrun, 1);
    run_sample(xorshift32());
  endtask

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    sample_strobe = 1'b0;
    sample        = '0;
    err_strobe    = 1'b0;
    err           = '0;
    load_strobe   = 1'b0;
    load_phase    = '0;
    load_row      = '0;
    rng_state     = 32'h7de6a452;
    m_phase       = 0;
    m_last        = 0;
    checks        = 0;
    errors        = 0;
    for (int i = 0; i < NUM_TAPS; i++) begin
      m_win[i] = '0;
    end
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    test_reset_state();
    test_impulse();
    test_random_filtering();
    test_adaptation();
    test_contention();
    test_overrun();

    repeat (2) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- lms_stage.f
verilog/lms_types_pkg.sv
verilog/lms_ctrl_pkg.sv
verilog/tap_memory.sv
verilog/tap_mem_arbiter.sv
verilog/stage_ctrl.sv
verilog/fir_output.sv
verilog/tap_update.sv
verilog/lms_stage_top.sv
tests/lms_stage_tb.sv

//--- Makefile
# Verilator build of the lms_stage testbench

VERILATOR ?= verilator
TOP       ?= lms_stage_tb
FILELIST  ?= lms_stage.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the simulation prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
